// File: hw/issue_config.svh
`ifndef ISSUE_CONFIG_SVH
`define ISSUE_CONFIG_SVH

// instructions offered by the queue per cycle
`define ISSUE_WIDTH 2

`define DATA_W    32
`define ROB_IDX_W 4
`define REG_IDX_W 5
`define COND_W    3

// branch condition codes, GT/GE/LT/LE test A against zero
`define COND_ALWAYS 3'd0
`define COND_EQ     3'd1
`define COND_NE     3'd2
`define COND_GT     3'd3
`define COND_GE     3'd4
`define COND_LT     3'd5
`define COND_LE     3'd6

`endif

// File: hw/issue_pkg.sv
`include "issue_config.svh"

package issue_pkg;

  typedef logic [`DATA_W-1:0]    data_t;
  typedef logic [`ROB_IDX_W-1:0] rob_idx_t;
  typedef logic [`REG_IDX_W-1:0] reg_idx_t;
  typedef logic [`COND_W-1:0]    cond_t;

  // one decoded entry from the instruction queue
  typedef struct packed {
    data_t    pc;
    logic     ls;
    logic     muldiv;
    logic     alu;
    logic     branch;
    logic     jump;
    reg_idx_t a_reg;
    logic     a_used;
    reg_idx_t b_reg;
    logic     b_used;
    reg_idx_t dest_reg;
    logic     dest_used;
    cond_t    cond;
    // jump target comes from operand A
    logic     rformat;
    data_t    target;
    rob_idx_t rob_slot;
  } issue_insn_t;

  // instruction with its resolved operands
  typedef struct packed {
    issue_insn_t insn;
    data_t       a_val;
    data_t       b_val;
  } issue_op_t;

  // ROB answer for one operand
  typedef struct packed {
    logic  present;
    logic  valid;
    data_t value;
  } rob_lookup_t;

  // link write from the branch unit
  typedef struct packed {
    rob_idx_t slot;
    data_t    result;
    reg_idx_t dest_reg;
    logic     dest_used;
    logic     redirect;
  } rob_write_t;

endpackage

// File: hw/operand_resolve.sv
`timescale 1ns/1ps

module operand_resolve (
  input  issue_pkg::issue_insn_t insn,
  input  issue_pkg::rob_lookup_t rob_a,
  input  issue_pkg::rob_lookup_t rob_b,
  input  issue_pkg::data_t       rf_a,
  input  issue_pkg::data_t       rf_b,
  output issue_pkg::data_t       a_val,
  output issue_pkg::data_t       b_val,
  output logic                   ready
);

  logic a_ok;
  logic b_ok;

  // a ROB hit shadows the register file
  assign a_val = rob_a.present ? rob_a.value : rf_a;
  assign b_val = rob_b.present ? rob_b.value : rf_b;

  // not in flight means the register file copy is current
  assign a_ok = !insn.a_used || !rob_a.present || rob_a.valid;
  assign b_ok = !insn.b_used || !rob_b.present || rob_b.valid;

  assign ready = a_ok && b_ok;

endmodule

// File: hw/issue_select.sv
`timescale 1ns/1ps
`include "issue_config.svh"

module issue_select (
  input  logic [`ISSUE_WIDTH-1:0] in_valid,
  input  issue_pkg::issue_insn_t  in_insn [`ISSUE_WIDTH],
  input  logic [`ISSUE_WIDTH-1:0] ops_ready,
  input  issue_pkg::data_t        a_val [`ISSUE_WIDTH],
  input  issue_pkg::data_t        b_val [`ISSUE_WIDTH],
  input  logic                    ls_free,
  input  logic                    alu_free,
  input  logic                    mul_free,
  output logic [`ISSUE_WIDTH-1:0] in_ready,
  output logic                    ls_load,
  output logic                    alu_load,
  output logic                    mul_load,
  output logic                    br_load,
  output issue_pkg::issue_op_t    ls_op,
  output issue_pkg::issue_op_t    alu_op,
  output issue_pkg::issue_op_t    mul_op,
  output issue_pkg::issue_op_t    br_op
);

  import issue_pkg::*;

  always_comb begin
    logic stop;

    stop     = 1'b0;
    in_ready = '0;
    ls_load  = 1'b0;
    alu_load = 1'b0;
    mul_load = 1'b0;
    br_load  = 1'b0;
    ls_op    = '0;
    alu_op   = '0;
    mul_op   = '0;
    br_op    = '0;

    // strictly in order, the first slot that cannot go stops the scan
    for (int i = 0; i < `ISSUE_WIDTH; i++) begin
      issue_op_t cand;

      cand.insn  = in_insn[i];
      cand.a_val = a_val[i];
      cand.b_val = b_val[i];

      if (!stop) begin
        if (!in_valid[i] || !ops_ready[i]) begin
          stop = 1'b1;
        end else if (in_insn[i].branch || in_insn[i].jump) begin
          // the resolver never stalls; a branch closes the group
          br_load     = 1'b1;
          br_op       = cand;
          in_ready[i] = 1'b1;
          stop        = 1'b1;
        end else if (in_insn[i].ls && ls_free && !ls_load) begin
          ls_load     = 1'b1;
          ls_op       = cand;
          in_ready[i] = 1'b1;
        end else if (in_insn[i].muldiv && mul_free && !mul_load) begin
          mul_load    = 1'b1;
          mul_op      = cand;
          in_ready[i] = 1'b1;
        end else if (in_insn[i].alu && alu_free && !alu_load) begin
          alu_load    = 1'b1;
          alu_op      = cand;
          in_ready[i] = 1'b1;
        end else if (in_insn[i].alu && mul_free && !mul_load) begin
          // overflow onto the multiply port
          mul_load    = 1'b1;
          mul_op      = cand;
          in_ready[i] = 1'b1;
        end else begin
          stop = 1'b1;
        end
      end
    end
  end

endmodule

// File: hw/dispatch_slot.sv
`timescale 1ns/1ps

module dispatch_slot (
  input  logic                 clock,
  input  logic                 reset_n,
  input  logic                 load,
  input  issue_pkg::issue_op_t load_op,
  input  logic                 ready,
  output logic                 free,
  output logic                 valid,
  output issue_pkg::issue_op_t op
);

  // empty now, or the unit takes the held op on this edge
  assign free = !valid || ready;

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      valid <= 1'b0;
    end else if (load) begin
      valid <= 1'b1;
    end else if (ready) begin
      valid <= 1'b0;
    end
  end

  // op only changes when a new instruction is loaded
  always_ff @(posedge clock) begin
    if (load) begin
      op <= load_op;
    end
  end

endmodule

// File: hw/branch_resolve.sv
`timescale 1ns/1ps
`include "issue_config.svh"

module branch_resolve (
  input  logic                  clock,
  input  logic                  reset_n,
  input  logic                  load,
  input  issue_pkg::issue_op_t  load_op,
  output issue_pkg::data_t      new_pc,
  output logic                  new_pc_valid,
  output logic                  flush,
  output issue_pkg::rob_write_t rob_wr,
  output logic                  rob_wr_valid
);

  import issue_pkg::*;

  logic      br_valid;
  issue_op_t br_op;
  data_t     a;
  data_t     b;
  logic      ab_equal;
  logic      a_eqz;
  logic      a_gez;
  logic      a_gtz;
  logic      cond_ok;
  logic      taken;

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      br_valid <= 1'b0;
    end else begin
      br_valid <= load;
    end
  end

  always_ff @(posedge clock) begin
    if (load) begin
      br_op <= load_op;
    end
  end

  assign a        = br_op.a_val;
  assign b        = br_op.b_val;
  assign ab_equal = (a == b);
  assign a_eqz    = (a == '0);
  // sign bit clear
  assign a_gez    = !a[`DATA_W-1];
  assign a_gtz    = a_gez && !a_eqz;

  always_comb begin
    case (br_op.insn.cond)
      `COND_ALWAYS: cond_ok = 1'b1;
      `COND_EQ:     cond_ok = ab_equal;
      `COND_NE:     cond_ok = !ab_equal;
      `COND_GT:     cond_ok = a_gtz;
      `COND_GE:     cond_ok = a_gez;
      `COND_LT:     cond_ok = !a_gez;
      `COND_LE:     cond_ok = !a_gtz;
      default:      cond_ok = 1'b0;
    endcase
  end

  assign taken        = br_op.insn.jump || (br_op.insn.branch && cond_ok);
  assign new_pc_valid = br_valid && taken;
  assign flush        = new_pc_valid;
  assign new_pc       = br_op.insn.rformat ? a : br_op.insn.target;

  // link value goes back to the branch's own ROB entry
  assign rob_wr_valid     = br_valid;
  assign rob_wr.slot      = br_op.insn.rob_slot;
  assign rob_wr.result    = br_op.insn.pc + data_t'(8);
  assign rob_wr.dest_reg  = br_op.insn.dest_reg;
  assign rob_wr.dest_used = br_op.insn.dest_used;
  assign rob_wr.redirect  = taken;

endmodule

// File: hw/issue_stage.sv
`timescale 1ns/1ps
`include "issue_config.svh"

module issue_stage (
  input  logic                    clock,
  input  logic                    reset_n,
  input  logic [`ISSUE_WIDTH-1:0] in_valid,
  input  issue_pkg::issue_insn_t  in_insn [`ISSUE_WIDTH],
  output logic [`ISSUE_WIDTH-1:0] in_ready,
  // the ROB matches rf_addr against entries older than rob_query
  output issue_pkg::rob_idx_t     rob_query [`ISSUE_WIDTH],
  input  issue_pkg::rob_lookup_t  rob_a [`ISSUE_WIDTH],
  input  issue_pkg::rob_lookup_t  rob_b [`ISSUE_WIDTH],
  // two register file read ports per slot, A at 2i and B at 2i+1
  output issue_pkg::reg_idx_t     rf_addr [2*`ISSUE_WIDTH],
  input  issue_pkg::data_t        rf_data [2*`ISSUE_WIDTH],
  output issue_pkg::issue_op_t    ls_op,
  output logic                    ls_valid,
  input  logic                    ls_ready,
  output issue_pkg::issue_op_t    alu_op,
  output logic                    alu_valid,
  input  logic                    alu_ready,
  output issue_pkg::issue_op_t    mul_op,
  output logic                    mul_valid,
  input  logic                    mul_ready,
  output issue_pkg::data_t        new_pc,
  output logic                    new_pc_valid,
  output logic                    flush,
  output issue_pkg::rob_write_t   rob_wr,
  output logic                    rob_wr_valid
);

  import issue_pkg::*;

  logic [`ISSUE_WIDTH-1:0] ops_ready;
  data_t                   a_val [`ISSUE_WIDTH];
  data_t                   b_val [`ISSUE_WIDTH];
  logic                    ls_free;
  logic                    alu_free;
  logic                    mul_free;
  logic                    ls_load;
  logic                    alu_load;
  logic                    mul_load;
  logic                    br_load;
  issue_op_t               ls_next;
  issue_op_t               alu_next;
  issue_op_t               mul_next;
  issue_op_t               br_next;

  for (genvar i = 0; i < `ISSUE_WIDTH; i++) begin : g_slot
    assign rob_query[i]     = in_insn[i].rob_slot;
    assign rf_addr[2*i]     = in_insn[i].a_reg;
    assign rf_addr[2*i + 1] = in_insn[i].b_reg;

    operand_resolve u_operands (
      .insn  (in_insn[i]),
      .rob_a (rob_a[i]),
      .rob_b (rob_b[i]),
      .rf_a  (rf_data[2*i]),
      .rf_b  (rf_data[2*i + 1]),
      .a_val (a_val[i]),
      .b_val (b_val[i]),
      .ready (ops_ready[i])
    );
  end

  issue_select u_select (
    .in_valid  (in_valid),
    .in_insn   (in_insn),
    .ops_ready (ops_ready),
    .a_val     (a_val),
    .b_val     (b_val),
    .ls_free   (ls_free),
    .alu_free  (alu_free),
    .mul_free  (mul_free),
    .in_ready  (in_ready),
    .ls_load   (ls_load),
    .alu_load  (alu_load),
    .mul_load  (mul_load),
    .br_load   (br_load),
    .ls_op     (ls_next),
    .alu_op    (alu_next),
    .mul_op    (mul_next),
    .br_op     (br_next)
  );

  dispatch_slot u_ls_port (
    .clock   (clock),
    .reset_n (reset_n),
    .load    (ls_load),
    .load_op (ls_next),
    .ready   (ls_ready),
    .free    (ls_free),
    .valid   (ls_valid),
    .op      (ls_op)
  );

  dispatch_slot u_alu_port (
    .clock   (clock),
    .reset_n (reset_n),
    .load    (alu_load),
    .load_op (alu_next),
    .ready   (alu_ready),
    .free    (alu_free),
    .valid   (alu_valid),
    .op      (alu_op)
  );

  dispatch_slot u_mul_port (
    .clock   (clock),
    .reset_n (reset_n),
    .load    (mul_load),
    .load_op (mul_next),
    .ready   (mul_ready),
    .free    (mul_free),
    .valid   (mul_valid),
    .op      (mul_op)
  );

  branch_resolve u_branch (
    .clock        (clock),
    .reset_n      (reset_n),
    .load         (br_load),
    .load_op      (br_next),
    .new_pc       (new_pc),
    .new_pc_valid (new_pc_valid),
    .flush        (flush),
    .rob_wr       (rob_wr),
    .rob_wr_valid (rob_wr_valid)
  );

endmodule

// File: testbench/issue_stage_sva.sv
`timescale 1ns/1ps
`include "issue_config.svh"

module issue_stage_sva (
  input logic                    clock,
  input logic                    reset_n,
  input logic [`ISSUE_WIDTH-1:0] in_valid,
  input issue_pkg::issue_insn_t  in_insn [`ISSUE_WIDTH],
  input logic [`ISSUE_WIDTH-1:0] in_ready,
  input logic                    ls_valid,
  input logic                    ls_ready,
  input issue_pkg::issue_op_t    ls_op,
  input logic                    alu_valid,
  input logic                    alu_ready,
  input issue_pkg::issue_op_t    alu_op,
  input logic                    mul_valid,
  input logic                    mul_ready,
  input issue_pkg::issue_op_t    mul_op,
  input logic                    flush,
  input logic                    rob_wr_valid
);

  logic br_accept;

  // a branch or jump is taken from the queue on this edge
  always_comb begin
    br_accept = 1'b0;
    for (int i = 0; i < `ISSUE_WIDTH; i++) begin
      if (in_valid[i] && in_ready[i] && (in_insn[i].branch || in_insn[i].jump)) begin
        br_accept = 1'b1;
      end
    end
  end

  // acceptance is always a prefix of the slots
  a_ready_prefix: assert property (@(posedge clock) disable iff (!reset_n)
    in_ready[1] |-> in_ready[0]) else $error("slot 1 accepted without slot 0");

  a_ls_hold: assert property (@(posedge clock) disable iff (!reset_n)
    ls_valid && !ls_ready |=> $stable(ls_op)) else $error("ls op changed while held");

  a_alu_hold: assert property (@(posedge clock) disable iff (!reset_n)
    alu_valid && !alu_ready |=> $stable(alu_op)) else $error("alu op changed while held");

  a_mul_hold: assert property (@(posedge clock) disable iff (!reset_n)
    mul_valid && !mul_ready |=> $stable(mul_op)) else $error("mul op changed while held");

  // the link write comes exactly one cycle after a branch is taken
  a_link_write: assert property (@(posedge clock) disable iff (!reset_n)
    rob_wr_valid == $past(br_accept))
    else $error("ROB link write not one cycle after a branch");

  // a redirect needs a branch accepted on the previous edge
  a_flush: assert property (@(posedge clock) disable iff (!reset_n)
    flush |-> $past(br_accept)) else $error("flush without an accepted branch");

endmodule

bind issue_stage issue_stage_sva u_sva (
  .clock        (clock),
  .reset_n      (reset_n),
  .in_valid     (in_valid),
  .in_insn      (in_insn),
  .in_ready     (in_ready),
  .ls_valid     (ls_valid),
  .ls_ready     (ls_ready),
  .ls_op        (ls_op),
  .alu_valid    (alu_valid),
  .alu_ready    (alu_ready),
  .alu_op       (alu_op),
  .mul_valid    (mul_valid),
  .mul_ready    (mul_ready),
  .mul_op       (mul_op),
  .flush        (flush),
  .rob_wr_valid (rob_wr_valid)
);

// File: testbench/issue_stage_tests.svh
`ifndef ISSUE_STAGE_TESTS_SVH
`define ISSUE_STAGE_TESTS_SVH

function automatic issue_insn_t alu_insn(input data_t pc, input reg_idx_t a,
                                         input reg_idx_t b, input rob_idx_t slot);
  issue_insn_t insn;
  insn          = '0;
  insn.pc       = pc;
  insn.alu      = 1'b1;
  insn.a_reg    = a;
  insn.a_used   = 1'b1;
  insn.b_reg    = b;
  insn.b_used   = 1'b1;
  insn.rob_slot = slot;
  return insn;
endfunction

// ROB value when present and the register file value otherwise
function automatic data_t operand_value(input reg_idx_t r);
  return rob_present[r] ? rob_value[r] : rf_table[r];
endfunction

function automatic issue_op_t expect_op(input issue_insn_t insn);
  issue_op_t op;
  op.insn  = insn;
  op.a_val = operand_value(insn.a_reg);
  op.b_val = operand_value(insn.b_reg);
  return op;
endfunction

function automatic logic cond_holds(input cond_t c, input data_t a, input data_t b);
  case (c)
    `COND_ALWAYS: return 1'b1;
    `COND_EQ:     return a == b;
    `COND_NE:     return a != b;
    `COND_GT:     return $signed(a) > 0;
    `COND_GE:     return $signed(a) >= 0;
    `COND_LT:     return $signed(a) < 0;
    `COND_LE:     return $signed(a) <= 0;
    default:      return 1'b0;
  endcase
endfunction

task automatic offer(input logic [1:0] valid, input issue_insn_t i0, input issue_insn_t i1);
  @(posedge clock);
  in_valid   <= valid;
  in_insn[0] <= i0;
  in_insn[1] <= i1;
endtask

task automatic release_slots();
  @(posedge clock);
  in_valid <= '0;
  @(negedge clock);
endtask

// called at a falling edge
task automatic wait_slot_ready(input int slot, input string test);
  int n;
  n = 0;
  while (!in_ready[slot]) begin
    if (n >= READY_TIMEOUT) stop_run({test, ": slot never became ready"});
    @(negedge clock);
    n++;
  end
endtask

task automatic after_reset();
  @(negedge clock);
  check_value("reset", 192'(0), 192'({ls_valid, alu_valid, mul_valid}));
  check_value("reset", 192'(0), 192'({rob_wr_valid, new_pc_valid, flush}));
endtask

task automatic operand_lookup();
  issue_insn_t ia;
  issue_insn_t ib;
  issue_op_t   exp;
  ia = alu_insn(32'h100, 5'd3, 5'd7, 4'd1);
  ib = alu_insn(32'h104, 5'd9, 5'd7, 4'd2);
  @(posedge clock);
  rob_present[3] <= 1'b1;
  rob_valid[3]   <= 1'b1;
  offer(2'b01, ia, '0);
  @(negedge clock);
  check_value("operands accept", 192'(1), 192'(in_ready));
  exp = expect_op(ia);
  release_slots();
  check_value("operands valid", 192'(1), 192'(alu_valid));
  check_value("operands op", 192'(exp), 192'(alu_op));
  // operand in flight waits for the ROB
  @(posedge clock);
  rob_present[9] <= 1'b1;
  rob_valid[9]   <= 1'b0;
  offer(2'b01, ib, '0);
  repeat (3) begin
    @(negedge clock);
    check_value("operands wait", 192'(0), 192'(in_ready));
  end
  @(posedge clock);
  rob_valid[9] <= 1'b1;
  @(negedge clock);
  wait_slot_ready(0, "operands wait");
  exp = expect_op(ib);
  release_slots();
  check_value("operands late op", 192'(exp), 192'(alu_op));
  check_value("operands late valid", 192'(1), 192'(alu_valid));
endtask

task automatic steering_order();
  issue_insn_t i0;
  issue_insn_t i1;
  i0 = alu_insn(32'h200, 5'd1, 5'd2, 4'd3);
  i0.alu = 1'b0;
  i0.ls  = 1'b1;
  i1 = alu_insn(32'h204, 5'd4, 5'd5, 4'd4);
  i1.alu    = 1'b0;
  i1.muldiv = 1'b1;
  offer(2'b11, i0, i1);
  @(negedge clock);
  check_value("ls muldiv accept", 192'(3), 192'(in_ready));
  check_value("rob query", 192'({i0.rob_slot, i1.rob_slot}),
              192'({rob_query[0], rob_query[1]}));
  release_slots();
  check_value("ls muldiv valid", 192'(3), 192'({ls_valid, mul_valid}));
  check_value("ls op", 192'(expect_op(i0)), 192'(ls_op));
  check_value("mul op", 192'(expect_op(i1)), 192'(mul_op));
  // two ALU ops where the second overflows to the mul port
  i0 = alu_insn(32'h208, 5'd6, 5'd8, 4'd5);
  i1 = alu_insn(32'h20c, 5'd10, 5'd11, 4'd6);
  offer(2'b11, i0, i1);
  @(negedge clock);
  check_value("alu pair accept", 192'(3), 192'(in_ready));
  release_slots();
  check_value("alu pair alu op", 192'(expect_op(i0)), 192'(alu_op));
  check_value("alu pair mul op", 192'(expect_op(i1)), 192'(mul_op));
  // blocked slot 0 holds back the muldiv behind it
  i0 = alu_insn(32'h210, 5'd9, 5'd2, 4'd7);
  i1.alu    = 1'b0;
  i1.muldiv = 1'b1;
  @(posedge clock);
  rob_valid[9] <= 1'b0;
  offer(2'b11, i0, i1);
  @(negedge clock);
  check_value("in order block", 192'(0), 192'(in_ready));
  release_slots();
  check_value("in order no issue", 192'(0), 192'(mul_valid));
  @(posedge clock);
  rob_present[9] <= 1'b0;
endtask

task automatic held_ports();
  issue_insn_t ia;
  issue_insn_t ib;
  issue_insn_t ic;
  int          alu_base;
  int          mul_base;
  ia = alu_insn(32'h300, 5'd12, 5'd13, 4'd8);
  ib = alu_insn(32'h304, 5'd14, 5'd15, 4'd9);
  ic = alu_insn(32'h308, 5'd16, 5'd17, 4'd10);
  @(negedge clock);
  alu_base = alu_taken;
  mul_base = mul_taken;
  @(posedge clock);
  alu_ready <= 1'b0;
  mul_ready <= 1'b0;
  offer(2'b11, ia, ib);
  @(negedge clock);
  check_value("bp first pair", 192'(3), 192'(in_ready));
  offer(2'b01, ic, '0);
  repeat (3) begin
    @(negedge clock);
    check_value("bp held valid", 192'(3), 192'({alu_valid, mul_valid}));
    check_value("bp held alu op", 192'(expect_op(ia)), 192'(alu_op));
    check_value("bp held mul op", 192'(expect_op(ib)), 192'(mul_op));
    check_value("bp blocked", 192'(0), 192'(in_ready));
  end
  @(posedge clock);
  alu_ready <= 1'b1;
  @(negedge clock);
  wait_slot_ready(0, "bp release");
  release_slots();
  check_value("bp third op", 192'(expect_op(ic)), 192'(alu_op));
  @(posedge clock);
  mul_ready <= 1'b1;
  repeat (3) @(negedge clock);
  check_value("bp alu count", 192'(alu_base + 2), 192'(alu_taken));
  check_value("bp mul count", 192'(mul_base + 1), 192'(mul_taken));
  check_value("bp drained", 192'(0), 192'({alu_valid, mul_valid}));
endtask

task automatic run_branch(input string name, input cond_t c, input logic jump,
                          input logic rformat, input data_t a, input data_t b);
  issue_insn_t br;
  issue_insn_t next;
  rob_write_t  exp_wr;
  logic        taken;
  br           = alu_insn(32'h1000 + {25'd0, c, 4'd0}, 5'd20, 5'd21, 4'd9);
  br.alu       = 1'b0;
  br.branch    = !jump;
  br.jump      = jump;
  br.cond      = c;
  br.rformat   = rformat;
  br.target    = 32'h4000_0040;
  br.dest_reg  = 5'd31;
  br.dest_used = jump;
  next = alu_insn(32'h1100, 5'd1, 5'd2, 4'd10);
  taken = jump || cond_holds(c, a, b);
  exp_wr.slot      = 4'd9;
  exp_wr.result    = br.pc + 32'd8;
  exp_wr.dest_reg  = 5'd31;
  exp_wr.dest_used = jump;
  exp_wr.redirect  = taken;
  @(posedge clock);
  rf_table[20] <= a;
  rf_table[21] <= b;
  offer(2'b11, br, next);
  @(negedge clock);
  check_value({name, " group end"}, 192'(1), 192'(in_ready));
  release_slots();
  check_value({name, " rob_wr_valid"}, 192'(1), 192'(rob_wr_valid));
  check_value({name, " redirect"}, 192'({taken, taken}), 192'({new_pc_valid, flush}));
  check_value({name, " rob_wr"}, 192'(exp_wr), 192'(rob_wr));
  if (taken) check_value({name, " new_pc"}, 192'(rformat ? a : br.target), 192'(new_pc));
  @(negedge clock);
  check_value({name, " one cycle"}, 192'(0), 192'({rob_wr_valid, new_pc_valid, flush}));
endtask

task automatic branch_outcomes();
  run_branch("always", `COND_ALWAYS, 1'b0, 1'b0, 32'd5, 32'd6);
  run_branch("eq hit", `COND_EQ, 1'b0, 1'b0, 32'd7, 32'd7);
  run_branch("eq miss", `COND_EQ, 1'b0, 1'b0, 32'd7, 32'd8);
  run_branch("ne", `COND_NE, 1'b0, 1'b0, 32'd7, 32'd8);
  run_branch("gt pos", `COND_GT, 1'b0, 1'b0, 32'd3, 32'd0);
  run_branch("gt zero", `COND_GT, 1'b0, 1'b0, 32'd0, 32'd0);
  run_branch("ge zero", `COND_GE, 1'b0, 1'b0, 32'd0, 32'd9);
  run_branch("lt neg", `COND_LT, 1'b0, 1'b0, 32'hffff_fff0, 32'd0);
  run_branch("lt pos", `COND_LT, 1'b0, 1'b0, 32'd1, 32'd0);
  run_branch("le zero", `COND_LE, 1'b0, 1'b0, 32'd0, 32'd1);
  run_branch("le pos", `COND_LE, 1'b0, 1'b0, 32'd4, 32'd1);
  run_branch("jump reg", `COND_NE, 1'b1, 1'b1, 32'h0000_8000, 32'h0000_8000);
endtask

`endif

// File: testbench/issue_stage_tb.sv
`timescale 1ns/1ps
`include "issue_config.svh"

module issue_stage_tb;

  import issue_pkg::*;

  // five tests of at most about 400 cycles each
  localparam int NUM_TESTS       = 5;
  localparam int CYCLES_PER_TEST = 400;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * CYCLES_PER_TEST;
  localparam int READY_TIMEOUT   = 20;

  logic                    clock;
  logic                    reset_n;
  logic [`ISSUE_WIDTH-1:0] in_valid;
  issue_insn_t             in_insn [`ISSUE_WIDTH];
  logic [`ISSUE_WIDTH-1:0] in_ready;
  rob_idx_t                rob_query [`ISSUE_WIDTH];
  rob_lookup_t             rob_a [`ISSUE_WIDTH];
  rob_lookup_t             rob_b [`ISSUE_WIDTH];
  reg_idx_t                rf_addr [2*`ISSUE_WIDTH];
  data_t                   rf_data [2*`ISSUE_WIDTH];
  issue_op_t               ls_op;
  issue_op_t               alu_op;
  issue_op_t               mul_op;
  logic                    ls_valid;
  logic                    alu_valid;
  logic                    mul_valid;
  logic                    ls_ready;
  logic                    alu_ready;
  logic                    mul_ready;
  data_t                   new_pc;
  logic                    new_pc_valid;
  logic                    flush;
  rob_write_t              rob_wr;
  logic                    rob_wr_valid;

  // ROB and register file contents by register number
  data_t       rf_table [32];
  logic        rob_present [32];
  logic        rob_valid [32];
  data_t       rob_value [32];
  logic [31:0] lfsr_state;
  int          error_count;
  int          alu_taken;
  int          mul_taken;

  issue_stage u_dut (.*);

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  always_comb begin
    for (int i = 0; i < `ISSUE_WIDTH; i++) begin
      rob_a[i].present = rob_present[rf_addr[2*i]];
      rob_a[i].valid   = rob_valid[rf_addr[2*i]];
      rob_a[i].value   = rob_value[rf_addr[2*i]];
      rob_b[i].present = rob_present[rf_addr[2*i + 1]];
      rob_b[i].valid   = rob_valid[rf_addr[2*i + 1]];
      rob_b[i].value   = rob_value[rf_addr[2*i + 1]];
    end
    for (int j = 0; j < 2*`ISSUE_WIDTH; j++) begin
      rf_data[j] = rf_table[rf_addr[j]];
    end
  end

  // count ops handed to the units
  always @(posedge clock) begin
    if (alu_valid && alu_ready) alu_taken <= alu_taken + 1;
    if (mul_valid && mul_ready) mul_taken <= mul_taken + 1;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clock);
    $display("watchdog expired before the tests finished");
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped by watchdog");
  end

  // fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic random_word(output data_t w);
    w = '0;
    for (int k = 0; k < `DATA_W; k++) begin
      lfsr_state = lfsr_step(lfsr_state);
      w = {w[`DATA_W-2:0], lfsr_state[0]};
    end
  endtask

  task automatic check_value(input string test, input logic [191:0] expected,
                             input logic [191:0] actual);
    if (expected !== actual) begin
      error_count++;
      $display("ERROR %s: expected %h, actual %h", test, expected, actual);
      $display("FAIL: see errors above");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic stop_run(input string what);
    $display("%s", what);
    $display("FAIL: see errors above");
    $fatal(1, "run stopped");
  endtask

  `include "issue_stage_tests.svh"

  initial begin
    data_t w;

    lfsr_state  = 32'h35a8974c;
    error_count = 0;
    alu_taken   = 0;
    mul_taken   = 0;
    reset_n     = 1'b0;
    in_valid    = '0;
    ls_ready    = 1'b1;
    alu_ready   = 1'b1;
    mul_ready   = 1'b1;
    for (int i = 0; i < `ISSUE_WIDTH; i++) in_insn[i] = '0;
    for (int r = 0; r < 32; r++) begin
      random_word(w);
      rf_table[r] = w;
      random_word(w);
      rob_value[r]   = w;
      rob_present[r] = 1'b0;
      rob_valid[r]   = 1'b0;
    end
    repeat (16) @(posedge clock);
    reset_n <= 1'b1;

    after_reset();
    operand_lookup();
    steering_order();
    held_ports();
    branch_outcomes();

    repeat (4) @(posedge clock);
    if (error_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: issue_stage.f
+incdir+hw
+incdir+testbench
hw/issue_pkg.sv
hw/operand_resolve.sv
hw/issue_select.sv
hw/dispatch_slot.sv
hw/branch_resolve.sv
hw/issue_stage.sv
testbench/issue_stage_sva.sv
testbench/issue_stage_tb.sv

// File: Makefile
# Verilator build and run for the issue stage testbench

VERILATOR ?= verilator
TOP       ?= issue_stage_tb
FILELIST  ?= issue_stage.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= PASS: all tests

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

test: $(OBJ_DIR)/V$(TOP)
	@out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
